// ==== project.f ====
+incdir+src
src/cpu_pkg.sv
src/cpu_ctrl.sv
src/cpu_regs.sv
src/cpu_alu.sv
src/cpu_ramctl.sv
src/cpu_pc.sv
src/cpu_top.sv
test/cpu_asserts.sv
test/cpu_tb.sv

// ==== Makefile ====
# Verilator build and run of the core testbench

TOP = cpu_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f project.f --top-module $(TOP)
	verilator --lint-only -f project.f --top-module cpu_top

obj_dir/V$(TOP): project.f src/*.sv src/*.svh test/*.sv
	verilator --binary --timing --assert -j 0 -f project.f --top-module $(TOP)

sim: obj_dir/V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	cat sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/cpu_tb.sv ====
// testbench of the core that assembles a program from a table, runs it and checks RAM and dump
`include "cpu_defines.svh"

module cpu_tb import cpu_pkg::*; ();

timeunit 1ns;
timeprecision 100ps;

localparam int E_ALU = 0, E_LDST = 1, E_DJNZ = 2, E_JR = 3, E_BANK = 4, E_PUSH = 5;
localparam int N_ENT = 14;
localparam int BASE = 16'h1000;     // data slot base in r7

typedef struct {
    int      kind;
    alu_fn_t fn;
    bit      rnd;
    word_t   a;
    word_t   b;
} entry_t;

logic clk = 0, rst = 1, cen = 0;
addr_t ram_addr;
word_t ram_dout = '0, ram_din;
logic [1:0] ram_we;
logic [7:0] dmp_addr = '0, dmp_din;
logic halted;

word_t  mem[0:4095];
word_t  shadow[0:4095];
entry_t tbl[0:N_ENT-1];
word_t  ref_r[0:7];         // bank 0 registers
flags_t ref_flags = '0;
int     exp_addr[$];
word_t  exp_val[$];
logic [31:0] rng = 32'h2495_15a7;
int wp = 0, slot = 0, errors = 0;

cpu_top dut(.*);

always #20 clk = ~clk;

function automatic logic [31:0] xorshift(input logic [31:0] seed);
    logic [31:0] s;
    s = seed;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
endfunction

always @(negedge clk) begin
    rng = xorshift(rng);
    cen <= rng[1:0] != 2'b00;  // about 3 in 4
end

// synchronous RAM with one cen edge of read latency
always @(posedge clk) begin
    if (cen) begin
        if (ram_we == 2'b11) begin
            mem[ram_addr[12:1]]    <= ram_din;
            shadow[ram_addr[12:1]] <= ram_din;
        end else begin
            ram_dout <= mem[ram_addr[12:1]];
        end
    end
end

// {S, Z, C} and the stored word, which for CP is rd unchanged
function automatic logic [18:0] ref_alu(input alu_fn_t fn, input word_t a, input word_t b);
    int    s;
    word_t r;
    logic  c;
    c = 1'b0;
    r = a;
    case (fn)
        ALU_ADD: begin
            s = int'(a) + int'(b);
            r = s[15:0];
            c = s > 65535;
        end
        ALU_SUB, ALU_CP: begin
            r = a - b;
            c = a < b;
        end
        ALU_AND: r = a & b;
        ALU_OR:  r = a | b;
        ALU_XOR: r = a ^ b;
        default: r = a;
    endcase
    return {r[15], r == 16'd0, c, (fn == ALU_CP) ? a : r};
endfunction

task automatic emit(input word_t w);
    mem[wp] = w;
    wp++;
endtask

task automatic load_word(input reg_sel_t rd, input word_t v);
    emit({OP_LDI, rd, 1'b0, v[7:0]});
    emit({OP_LDH, rd, 1'b0, v[15:8]});
    ref_r[rd] = v;
endtask

task automatic store(input reg_sel_t rd, input word_t v);
    emit({OP_ST, rd, 3'd7, slot[5:0]});
    exp_addr.push_back(BASE + 2 * slot);
    exp_val.push_back(v);
    slot++;
endtask

task automatic alu_entry(input alu_fn_t fn, input word_t a, input word_t b);
    logic [18:0] r;
    r = ref_alu(fn, a, b);
    load_word(3'd1, a);
    load_word(3'd2, b);
    emit({OP_ALU, 3'd1, 3'd2, fn, 3'd0});
    ref_flags = r[18:16];
    ref_r[1]  = r[15:0];
    store(3'd1, r[15:0]);
endtask

task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        errors++;
    end
endtask

task automatic assemble();
    entry_t e;
    word_t  a, b;
    logic [18:0] r;
    foreach (ref_r[i]) ref_r[i] = '0;
    load_word(3'd7, BASE);
    for (int i = 0; i < N_ENT; i++) begin
        e = tbl[i];
        a = e.a;
        b = e.b;
        if (e.rnd) begin
            rng = xorshift(rng);
            a = rng[15:0];
            b = rng[31:16];
        end
        case (e.kind)
            E_ALU: alu_entry(e.fn, a, b);
            E_LDST: begin
                load_word(3'd3, a);
                store(3'd3, a);
                emit({OP_LD, 3'd4, 3'd7, slot[5:0] - 6'd1});  // reload the slot just written
                ref_r[4] = a;
                store(3'd4, a);
            end
            E_DJNZ: begin
                load_word(3'd5, a);
                load_word(3'd6, 16'd0);
                load_word(3'd3, b);
                emit({OP_ALU, 3'd6, 3'd3, ALU_ADD, 3'd0});
                emit({OP_DJNZ, 3'd5, 1'b0, 8'hFE});           // back to the ADD
                r = ref_alu(ALU_ADD, (a - 16'd1) * b, b);
                ref_flags = r[18:16];
                ref_r[5]  = 16'd0;
                ref_r[6]  = a * b;
                store(3'd6, a * b);
            end
            E_JR: begin
                alu_entry(ALU_CP, a, b);
                emit({OP_LDI, 3'd3, 1'b0, 8'h11});
                emit({OP_JR, CC_NZ, 1'b0, 8'd1});             // skips the second marker
                emit({OP_LDI, 3'd3, 1'b0, 8'h22});
                ref_r[3] = (a != b) ? 16'h0011 : 16'h0022;
                store(3'd3, ref_r[3]);
            end
            E_BANK: begin
                load_word(3'd1, a);
                emit({OP_INCF, 12'd0});
                load_word(3'd7, BASE);                        // bank 1 has its own r7
                load_word(3'd1, b);
                store(3'd1, b);
                emit({OP_DECF, 12'd0});
                ref_r[1] = a;
                store(3'd1, a);
            end
            E_PUSH: begin
                for (int k = 0; k < 3; k++) begin
                    load_word(3'd3, (k == 2) ? (a ^ b) : (k == 1 ? b : a));
                    emit({OP_PUSH, 3'd3, 9'd0});
                    exp_addr.push_back(`CPU_XSP_RESET - 2 * (k + 1));
                    exp_val.push_back(ref_r[3]);
                end
            end
            default: emit({OP_NOP, 12'd0});
        endcase
    end
    emit({OP_HALT, 12'd0});
endtask

initial begin
    #(((N_ENT + 1) * 40 + 10) * 40);     // one extra entry for setup and HALT
    $display("watchdog expired before the core halted");
    $display("Test failed");
    $finish;
end

initial begin
    word_t w;
    tbl[0]  = '{E_ALU,  ALU_ADD, 1, 16'h0000, 16'h0000};
    tbl[1]  = '{E_ALU,  ALU_ADD, 0, 16'hFFFF, 16'h0001};
    tbl[2]  = '{E_ALU,  ALU_SUB, 1, 16'h0000, 16'h0000};
    tbl[3]  = '{E_ALU,  ALU_SUB, 0, 16'h0001, 16'h0002};
    tbl[4]  = '{E_ALU,  ALU_AND, 1, 16'h0000, 16'h0000};
    tbl[5]  = '{E_ALU,  ALU_OR,  1, 16'h0000, 16'h0000};
    tbl[6]  = '{E_ALU,  ALU_XOR, 1, 16'h0000, 16'h0000};
    tbl[7]  = '{E_LDST, ALU_ADD, 1, 16'h0000, 16'h0000};
    tbl[8]  = '{E_DJNZ, ALU_ADD, 0, 16'h0005, 16'h3334};
    tbl[9]  = '{E_JR,   ALU_CP,  0, 16'h1234, 16'h1234};
    tbl[10] = '{E_JR,   ALU_CP,  1, 16'h0000, 16'h0000};
    tbl[11] = '{E_BANK, ALU_ADD, 1, 16'h0000, 16'h0000};
    tbl[12] = '{E_PUSH, ALU_ADD, 1, 16'h0000, 16'h0000};
    tbl[13] = '{E_ALU,  ALU_CP,  1, 16'h0000, 16'h0000};   // last flag update
    for (int i = 0; i < 4096; i++) begin
        mem[i] = i[15:0] ^ 16'hA5C3;
        shadow[i] = ~mem[i];                // unwritten slots never match
    end
    assemble();
    repeat (10) @(negedge clk);
    rst = 0;
    while (!halted) @(negedge clk);
    foreach (exp_addr[i]) begin
        check($sformatf("ram[%h]", exp_addr[i]), shadow[exp_addr[i] >> 1], exp_val[i]);
    end
    for (int i = 0; i < 22; i++) begin
        @(negedge clk);
        dmp_addr = i[7:0];
        @(posedge clk);
        if (i < 16) begin
            w = ref_r[i / 2];
            check($sformatf("dmp_din[%0d]", i), dmp_din, (i % 2) ? w[15:8] : w[7:0]);
        end else if (i == 16) begin
            check("dmp_din flags", dmp_din, ref_flags);
        end else if (i == 17) begin
            check("dmp_din bank", dmp_din, 0);
        end else if (i < 21) begin
            check($sformatf("dmp_din[%0d]", i), dmp_din,
                  ((`CPU_XSP_RESET - 6) >> (8 * (i - 18))) & 8'hFF);
        end else begin
            check("dmp_din unmapped", dmp_din, 0);
        end
    end
    $display("checks done, %0d stores, %0d errors", exp_addr.size(), errors);
    if (errors == 0) begin
        $display("Test completed successfully");
    end else begin
        $display("Test failed");
    end
    $finish;
end

endmodule

// ==== test/cpu_asserts.sv ====
// bus and status assertions bound to the top level of the core
module cpu_asserts (
    input logic       clk,
    input logic       rst,
    input logic [1:0] ram_we,
    input logic       halted,
    input logic [7:0] dmp_din
);

timeunit 1ns;
timeprecision 100ps;

// write strobes are cleared by reset
assert property (@(posedge clk) rst |=> ram_we == 2'b00)
    else $error("ram_we not cleared during reset");

// once halted, only reset leaves it
assert property (@(posedge clk) disable iff (rst) halted |=> halted)
    else $error("halted fell without reset");

assert property (@(posedge clk) disable iff (rst) ram_we == 2'b00 || ram_we == 2'b11)
    else $error("partial byte write on ram_we");

assert property (@(posedge clk) disable iff (rst) !$isunknown(dmp_din))
    else $error("dump data unknown");

endmodule

bind cpu_top cpu_asserts u_asserts (
    .clk     ( clk     ),
    .rst     ( rst     ),
    .ram_we  ( ram_we  ),
    .halted  ( halted  ),
    .dmp_din ( dmp_din )
);

// ==== src/cpu_top.sv ====
// top level of the 16-bit register-bank core with RAM bus and debug dump port
module cpu_top import cpu_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,

    output addr_t      ram_addr,
    input  word_t      ram_dout,
    output word_t      ram_din,
    output logic [1:0] ram_we,

    // register dump
    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din,

    output logic       halted
);

// RAM side
addr_t      pc, xsp, idx_addr;
word_t      buf_dout;
logic       buf_rdy;
logic       ram_ren, ram_wen;
logic [1:0] addr_sel;

// register file
word_t      src_out, dst_out;
reg_sel_t   src, dst;
logic [1:0] wsel;
logic       regs_we;
logic       inc_rfp, dec_rfp, dec_xsp;

// ALU and PC
word_t      imm, alu_dout;
alu_fn_t    alu_fn;
flags_t     flags;
logic       alu_go, ldh, dec;
logic       pc_we, pc_rel;

cpu_ctrl u_ctrl(
    .rst        ( rst       ),
    .clk        ( clk       ),
    .cen        ( cen       ),
    .op         ( buf_dout  ),
    .op_ok      ( buf_rdy   ),
    .flags      ( flags     ),
    .src_out    ( src_out   ),
    .dst_out    ( dst_out   ),
    .ram_ren    ( ram_ren   ),
    .ram_wen    ( ram_wen   ),
    .addr_sel   ( addr_sel  ),
    .idx_addr   ( idx_addr  ),
    .pc_we      ( pc_we     ),
    .pc_rel     ( pc_rel    ),
    .imm        ( imm       ),
    .regs_we    ( regs_we   ),
    .dst        ( dst       ),
    .src        ( src       ),
    .wsel       ( wsel      ),
    .inc_rfp    ( inc_rfp   ),
    .dec_rfp    ( dec_rfp   ),
    .dec_xsp    ( dec_xsp   ),
    .alu_fn     ( alu_fn    ),
    .alu_go     ( alu_go    ),
    .ldh        ( ldh       ),
    .dec        ( dec       ),
    .halted     ( halted    )
);

cpu_regs u_regs(
    .rst        ( rst       ),
    .clk        ( clk       ),
    .cen        ( cen       ),
    .src        ( src       ),
    .dst        ( dst       ),
    .regs_we    ( regs_we   ),
    .wsel       ( wsel      ),
    .alu_dout   ( alu_dout  ),
    .ram_data   ( buf_dout  ),
    .imm        ( imm       ),
    .inc_rfp    ( inc_rfp   ),
    .dec_rfp    ( dec_rfp   ),
    .dec_xsp    ( dec_xsp   ),
    .flags      ( flags     ),
    .src_out    ( src_out   ),
    .dst_out    ( dst_out   ),
    .xsp        ( xsp       ),
    .dmp_addr   ( dmp_addr  ),
    .dmp_din    ( dmp_din   )
);

cpu_alu u_alu(
    .rst        ( rst       ),
    .clk        ( clk       ),
    .cen        ( cen       ),
    .op0        ( dst_out   ),
    .op1        ( src_out   ),
    .imm        ( imm       ),
    .alu_fn     ( alu_fn    ),
    .alu_go     ( alu_go    ),
    .ldh        ( ldh       ),
    .dec        ( dec       ),
    .alu_dout   ( alu_dout  ),
    .flags      ( flags     )
);

cpu_ramctl u_ramctl(
    .rst        ( rst       ),
    .clk        ( clk       ),
    .cen        ( cen       ),
    .pc         ( pc        ),
    .xsp        ( xsp       ),
    .idx_addr   ( idx_addr  ),
    .addr_sel   ( addr_sel  ),
    .ram_ren    ( ram_ren   ),
    .ram_wen    ( ram_wen   ),
    .wdata      ( dst_out   ),     // ST and PUSH store rd
    .ram_addr   ( ram_addr  ),
    .ram_din    ( ram_din   ),
    .ram_we     ( ram_we    ),
    .ram_dout   ( ram_dout  ),
    .dout       ( buf_dout  ),
    .ram_rdy    ( buf_rdy   )
);

cpu_pc u_pc(
    .rst        ( rst       ),
    .clk        ( clk       ),
    .cen        ( cen       ),
    .op_ok      ( buf_rdy   ),
    .we         ( pc_we     ),
    .rel        ( pc_rel    ),
    .imm        ( imm       ),
    .pc         ( pc        )
);

endmodule

// ==== src/cpu_pc.sv ====
// program counter: word step on each fetch, relative branch load
`include "cpu_defines.svh"

module cpu_pc import cpu_pkg::*; (
    input  logic  rst,
    input  logic  clk,
    input  logic  cen,
    input  logic  op_ok,
    input  logic  we,
    input  logic  rel,
    input  word_t imm,      // signed word offset
    output addr_t pc
);

addr_t offset;

assign offset = {{7{imm[15]}}, imm, 1'b0};

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= `CPU_PC_RESET;
    end else if (cen) begin
        if (we) begin
            if (rel) pc <= pc + offset;     // we alone freezes the pc
        end else if (op_ok) begin
            pc <= pc + 24'd2;
        end
    end
end

endmodule

// ==== src/cpu_ramctl.sv ====
// RAM controller: address source mux, registered write strobes, read capture
module cpu_ramctl import cpu_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,

    input  addr_t      pc,
    input  addr_t      xsp,
    input  addr_t      idx_addr,
    input  logic [1:0] addr_sel,
    input  logic       ram_ren,
    input  logic       ram_wen,
    input  word_t      wdata,

    output addr_t      ram_addr,
    output word_t      ram_din,
    output logic [1:0] ram_we,
    input  word_t      ram_dout,

    output word_t      dout,
    output logic       ram_rdy
);

word_t dout_q;      // last word read

always_comb begin
    case (addr_sel)
        ASEL_IDX: ram_addr = idx_addr;
        ASEL_XSP: ram_addr = xsp;
        default:  ram_addr = pc;
    endcase
end

// live RAM data during the strobe, held copy afterwards
assign dout = ram_rdy ? ram_dout : dout_q;

always_ff @(posedge clk) begin
    if (rst) begin
        ram_we  <= 2'b00;
        ram_rdy <= 1'b0;
    end else if (cen) begin
        ram_we  <= ram_wen ? 2'b11 : 2'b00;    // always a full word
        ram_rdy <= ram_ren;
    end
end

always_ff @(posedge clk) begin
    if (cen) begin
        if (ram_wen) ram_din <= wdata;
        if (ram_rdy) dout_q <= ram_dout;
    end
end

endmodule

// ==== src/cpu_alu.sv ====
// arithmetic and logic unit of the core, with the S/Z/C flags register
module cpu_alu import cpu_pkg::*; (
    input  logic    rst,
    input  logic    clk,
    input  logic    cen,
    input  word_t   op0,            // rd
    input  word_t   op1,            // rs
    input  word_t   imm,
    input  alu_fn_t alu_fn,
    input  logic    alu_go,
    input  logic    ldh,
    input  logic    dec,
    output word_t   alu_dout,
    output flags_t  flags
);

logic [16:0] sum;       // extra bit holds carry or borrow
logic        carry;

always_comb begin
    sum      = '0;
    carry    = 1'b0;
    alu_dout = op0;
    if (ldh) begin
        alu_dout = {imm[7:0], op0[7:0]};   // low byte kept
    end else if (dec) begin
        alu_dout = op0 - 16'd1;
    end else begin
        case (alu_fn)
            ALU_ADD: begin
                sum      = {1'b0, op0} + {1'b0, op1};
                alu_dout = sum[15:0];
                carry    = sum[16];
            end
            ALU_SUB, ALU_CP: begin
                sum      = {1'b0, op0} - {1'b0, op1};
                alu_dout = sum[15:0];
                carry    = sum[16];         // borrow
            end
            ALU_AND: alu_dout = op0 & op1;
            ALU_OR:  alu_dout = op0 | op1;
            ALU_XOR: alu_dout = op0 ^ op1;
            default: alu_dout = op0;
        endcase
    end
end

// LDH and DJNZ go through the ALU but keep the flags
always_ff @(posedge clk) begin
    if (rst) begin
        flags <= '0;
    end else if (cen && alu_go && !ldh && !dec) begin
        flags[FLAG_S] <= alu_dout[15];
        flags[FLAG_Z] <= alu_dout == 16'd0;
        flags[FLAG_C] <= carry;
    end
end

endmodule

// ==== src/cpu_regs.sv ====
// register file with four banks of eight words, bank pointer, stack pointer and dump port
`include "cpu_defines.svh"

module cpu_regs import cpu_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,

    input  reg_sel_t   src,
    input  reg_sel_t   dst,
    input  logic       regs_we,
    input  logic [1:0] wsel,
    input  word_t      alu_dout,
    input  word_t      ram_data,
    input  word_t      imm,
    input  logic       inc_rfp,
    input  logic       dec_rfp,
    input  logic       dec_xsp,
    input  flags_t     flags,       // only shown on the dump port

    output word_t      src_out,
    output word_t      dst_out,
    output addr_t      xsp,

    input  logic [7:0] dmp_addr,
    output logic [7:0] dmp_din
);

word_t rf[0:31];    // {bank, register}
bank_t rfp;
word_t wdata;
word_t dmp_reg;

assign src_out = rf[{rfp, src}];
assign dst_out = rf[{rfp, dst}];
assign dmp_reg = rf[{rfp, dmp_addr[3:1]}];

always_comb begin
    case (wsel)
        WSEL_RAM: wdata = ram_data;
        WSEL_IMM: wdata = imm;
        default:  wdata = alu_dout;
    endcase
end

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < 32; i++) begin
            rf[i] <= '0;
        end
        rfp <= '0;
        xsp <= `CPU_XSP_RESET;
    end else if (cen) begin
        if (regs_we) rf[{rfp, dst}] <= wdata;
        if (inc_rfp) begin
            rfp <= rfp + 2'd1;      // wraps modulo 4
        end else if (dec_rfp) begin
            rfp <= rfp - 2'd1;
        end
        if (dec_xsp) xsp <= xsp - 24'd2;
    end
end

// debug byte map, current bank only
always_comb begin
    dmp_din = 8'h00;
    if (dmp_addr < 8'd16) begin
        dmp_din = dmp_addr[0] ? dmp_reg[15:8] : dmp_reg[7:0];
    end else begin
        case (dmp_addr)
            8'd16:   dmp_din = {5'd0, flags};
            8'd17:   dmp_din = {6'd0, rfp};
            8'd18:   dmp_din = xsp[7:0];
            8'd19:   dmp_din = xsp[15:8];
            8'd20:   dmp_din = xsp[23:16];
            default: dmp_din = 8'h00;
        endcase
    end
end

endmodule

// ==== src/cpu_ctrl.sv ====
// instruction decoder and sequencer, with the indexed address adder and branch tests
module cpu_ctrl import cpu_pkg::*; (
    input  logic       rst,
    input  logic       clk,
    input  logic       cen,

    input  word_t      op,          // fetched word
    input  logic       op_ok,
    input  flags_t     flags,
    input  word_t      src_out,
    input  word_t      dst_out,

    output logic       ram_ren,
    output logic       ram_wen,
    output logic [1:0] addr_sel,
    output addr_t      idx_addr,

    output logic       pc_we,
    output logic       pc_rel,
    output word_t      imm,

    output logic       regs_we,
    output reg_sel_t   dst,
    output reg_sel_t   src,
    output logic [1:0] wsel,
    output logic       inc_rfp,
    output logic       dec_rfp,
    output logic       dec_xsp,

    output alu_fn_t    alu_fn,
    output logic       alu_go,
    output logic       ldh,
    output logic       dec,         // DJNZ decrement
    output logic       halted
);

ctrl_state_t st, nx_st;
word_t       ir;                    // instruction being executed
logic [3:0]  opc;
logic        jr_ok;
logic        djnz_ok;

assign opc    = ir[15:12];
assign dst    = ir[11:9];
assign src    = ir[8:6];
assign alu_fn = ir[5:3];
assign halted = st == HALTED;

// register plus unsigned word offset
assign idx_addr = {8'd0, src_out} + {17'd0, ir[5:0], 1'b0};

// branch offsets are signed, LDI/LDH immediates are not
assign imm = (opc == OP_JR || opc == OP_DJNZ) ? {{8{ir[7]}}, ir[7:0]} : {8'd0, ir[7:0]};

always_comb begin
    case (ir[11:9])
        CC_ALWAYS: jr_ok = 1'b1;
        CC_Z:      jr_ok = flags[FLAG_Z];
        CC_NZ:     jr_ok = !flags[FLAG_Z];
        CC_C:      jr_ok = flags[FLAG_C];
        CC_NC:     jr_ok = !flags[FLAG_C];
        default:   jr_ok = 1'b0;
    endcase
end

// the ALU decrement is zero exactly when rd holds 1
assign djnz_ok = dst_out != 16'd1;

always_ff @(posedge clk) begin
    if (rst) begin
        st <= FETCH;
        ir <= '0;
    end else if (cen) begin
        st <= nx_st;
        if (st == WAIT_OP && op_ok) ir <= op;
    end
end

always_comb begin
    nx_st    = st;
    ram_ren  = 1'b0;
    ram_wen  = 1'b0;
    addr_sel = ASEL_PC;
    pc_we    = 1'b0;
    pc_rel   = 1'b0;
    regs_we  = 1'b0;
    wsel     = WSEL_ALU;
    inc_rfp  = 1'b0;
    dec_rfp  = 1'b0;
    dec_xsp  = 1'b0;
    alu_go   = 1'b0;
    ldh      = 1'b0;
    dec      = 1'b0;
    case (st)
        FETCH: begin
            ram_ren = 1'b1;
            nx_st   = WAIT_OP;
        end
        WAIT_OP: begin
            if (op_ok) nx_st = EXEC;
        end
        EXEC: begin
            nx_st = FETCH;
            case (opc)
                OP_NOP:  nx_st = FETCH;
                OP_LDI: begin
                    regs_we = 1'b1;
                    wsel    = WSEL_IMM;
                end
                OP_LDH: begin
                    regs_we = 1'b1;
                    alu_go  = 1'b1;
                    ldh     = 1'b1;
                end
                OP_ALU: begin
                    alu_go  = 1'b1;
                    regs_we = alu_fn != ALU_CP;
                end
                OP_LD:   nx_st = MEM_RD;
                OP_ST: begin
                    ram_wen = 1'b1;         // strobe shows up in MEM_WR
                    nx_st   = MEM_WR;
                end
                OP_JR: begin
                    pc_we  = jr_ok;
                    pc_rel = 1'b1;
                end
                OP_DJNZ: begin
                    regs_we = 1'b1;
                    alu_go  = 1'b1;
                    dec     = 1'b1;
                    pc_we   = djnz_ok;
                    pc_rel  = 1'b1;
                end
                OP_INCF: inc_rfp = 1'b1;
                OP_DECF: dec_rfp = 1'b1;
                OP_PUSH: begin
                    dec_xsp = 1'b1;         // xsp is already lowered in MEM_WR
                    ram_wen = 1'b1;
                    nx_st   = MEM_WR;
                end
                OP_HALT: nx_st = HALTED;
                default: nx_st = FETCH;     // undefined codes
            endcase
        end
        MEM_RD: begin
            ram_ren  = 1'b1;
            addr_sel = ASEL_IDX;
            nx_st    = MEM_WAIT;
        end
        MEM_WAIT: begin
            addr_sel = ASEL_IDX;
            pc_we    = 1'b1;                // ready strobe is data, pc holds
            if (op_ok) begin
                regs_we = 1'b1;
                wsel    = WSEL_RAM;
                nx_st   = FETCH;
            end
        end
        MEM_WR: begin
            addr_sel = opc == OP_PUSH ? ASEL_XSP : ASEL_IDX;
            nx_st    = FETCH;
        end
        HALTED:  nx_st = HALTED;
        default: nx_st = FETCH;
    endcase
end

endmodule

// ==== src/cpu_pkg.sv ====
// shared types, opcodes, condition codes and controller states of the core
`include "cpu_defines.svh"

package cpu_pkg;

typedef logic [`CPU_AW-1:0] addr_t;     // byte address
typedef logic [`CPU_DW-1:0] word_t;     // data word
typedef logic [2:0]         reg_sel_t;  // register number within a bank
typedef logic [1:0]         bank_t;     // bank pointer
typedef logic [2:0]         alu_fn_t;
typedef logic [2:0]         flags_t;    // {S, Z, C}

// bit positions inside flags_t
localparam int FLAG_S = 2;
localparam int FLAG_Z = 1;
localparam int FLAG_C = 0;

localparam alu_fn_t ALU_ADD = 3'd0;
localparam alu_fn_t ALU_SUB = 3'd1;
localparam alu_fn_t ALU_AND = 3'd2;
localparam alu_fn_t ALU_OR  = 3'd3;
localparam alu_fn_t ALU_XOR = 3'd4;
localparam alu_fn_t ALU_CP  = 3'd5;   // flags only

// instruction bits 15:12
localparam logic [3:0] OP_NOP  = 4'h0;
localparam logic [3:0] OP_LDI  = 4'h1;
localparam logic [3:0] OP_LDH  = 4'h2;
localparam logic [3:0] OP_ALU  = 4'h3;
localparam logic [3:0] OP_LD   = 4'h4;
localparam logic [3:0] OP_ST   = 4'h5;
localparam logic [3:0] OP_JR   = 4'h6;
localparam logic [3:0] OP_DJNZ = 4'h7;
localparam logic [3:0] OP_INCF = 4'h8;
localparam logic [3:0] OP_DECF = 4'h9;
localparam logic [3:0] OP_PUSH = 4'hA;
localparam logic [3:0] OP_HALT = 4'hF;

// JR conditions, instruction bits 11:9
localparam logic [2:0] CC_ALWAYS = 3'd0;
localparam logic [2:0] CC_Z      = 3'd1;
localparam logic [2:0] CC_NZ     = 3'd2;
localparam logic [2:0] CC_C      = 3'd3;
localparam logic [2:0] CC_NC     = 3'd4;

// RAM address source
localparam logic [1:0] ASEL_PC  = 2'd0;
localparam logic [1:0] ASEL_IDX = 2'd1;
localparam logic [1:0] ASEL_XSP = 2'd2;

// register write data source
localparam logic [1:0] WSEL_ALU = 2'd0;
localparam logic [1:0] WSEL_RAM = 2'd1;
localparam logic [1:0] WSEL_IMM = 2'd2;

typedef enum logic [2:0] {
    FETCH,
    WAIT_OP,
    EXEC,
    MEM_RD,
    MEM_WAIT,
    MEM_WR,
    HALTED
} ctrl_state_t;

endpackage

// ==== src/cpu_defines.svh ====
// global widths and reset values of the 16-bit register-bank core
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

// bus widths
`define CPU_AW 24           // byte address
`define CPU_DW 16           // data word

// program counter after reset
`define CPU_PC_RESET 24'h000000

// stack grows downwards
// PUSH pre-decrements by 2 before the write
`define CPU_XSP_RESET 24'h000800

`endif
